/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_ucore
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
PASS_MSG  = test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -x "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* source/alu_flags.sv */
`default_nettype none

module alu_flags (
    input  logic           clk,
    input  logic           rst,
    input  ucore_pkg::op_t op,
    input  logic [7:0]     imm,
    input  logic           alu_go,
    input  logic           acc_we,
    input  logic           flags_we,
    output logic [7:0]     acc,
    output logic [7:0]     flags
);
    import ucore_pkg::*;

    logic [8:0] sum;                        // bit 8 is carry
    logic [8:0] diff;                       // bit 8 is borrow
    logic [4:0] sum_lo;                     // low nibble add
    logic [4:0] diff_lo;                    // low nibble subtract
    logic [7:0] res;
    logic [7:0] nf;                         // next flag set
    logic [7:0] res_q;                      // held until acc_we
    logic [7:0] nf_q;                       // held until flags_we

    assign sum     = {1'b0, acc} + {1'b0, imm};
    assign diff    = {1'b0, acc} - {1'b0, imm};
    assign sum_lo  = {1'b0, acc[3:0]} + {1'b0, imm[3:0]};
    assign diff_lo = {1'b0, acc[3:0]} - {1'b0, imm[3:0]};

    always_comb begin
        nf  = '0;                           // unlisted flags clear
        res = acc;
        case (op)
            OP_LD, OP_CLD: res = imm;
            OP_ADD, OP_CADD: begin
                res     = sum[7:0];
                nf[FH]  = sum_lo[4];        // carry out of bit 3
                nf[FV]  = (acc[7] == imm[7]) && (sum[7] != acc[7]);
                nf[FC]  = sum[8];
            end
            OP_SUB, OP_CMP: begin
                res     = diff[7:0];
                nf[FH]  = diff_lo[4];       // borrow into bit 4
                nf[FV]  = (acc[7] != imm[7]) && (diff[7] != acc[7]);
                nf[FN]  = 1'b1;
                nf[FC]  = diff[8];
            end
            OP_AND: begin
                res     = acc & imm;
                nf[FH]  = 1'b1;
            end
            OP_OR:   res = acc | imm;
            OP_XOR:  res = acc ^ imm;
            default: res = acc;             // nop keeps acc
        endcase
        nf[FS] = res[7];
        nf[FZ] = res == 8'd0;
    end

    always_ff @(posedge clk) begin
        if (alu_go) begin
            res_q <= res;
            nf_q  <= nf;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            acc   <= '0;
            flags <= '0;
        end else begin
            if (acc_we) acc <= res_q;       // WRACC step
            if (flags_we) flags <= nf_q;    // flag routine step
        end
    end

endmodule

`default_nettype wire

/* source/apb_port.sv */
`default_nettype none

module apb_port (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    input  logic        full,
    input  logic        empty,
    input  logic        busy_seq,
    input  logic [7:0]  acc,
    input  logic [7:0]  flags,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        push,
    output logic [15:0] push_data
);
    import ucore_pkg::*;

    logic        setup;                         // first apb cycle
    logic        access;                        // second apb cycle
    logic        is_cmd;
    logic        is_ro;
    logic        busy;
    logic        err;
    logic [31:0] rd_mux;

    assign setup  = psel && !penable;
    assign access = psel && penable;
    assign is_cmd = paddr == A_CMD;
    assign busy   = busy_seq || !empty;         // queued work counts as busy

    // read side decode, also tells which addresses are readable
    always_comb begin
        is_ro  = 1'b1;
        rd_mux = '0;
        case (paddr)
            A_ACC:    rd_mux = {24'd0, acc};
            A_FLAGS:  rd_mux = {24'd0, flags};
            A_STATUS: rd_mux = {29'd0, empty, full, busy};
            default:  is_ro = 1'b0;             // cmd and unmapped
        endcase
    end

    // error cases per direction
    always_comb begin
        if (pwrite) begin
            err = !is_cmd || full;              // ro target or no room
        end else begin
            err = !is_ro;                       // cmd read or hole
        end
    end

    assign pready    = 1'b1;                    // zero wait states
    assign pslverr   = access && err;
    assign push      = access && pwrite && is_cmd && !full;  // full drops the word
    assign push_data = pwdata[15:0];

    // read data sampled in setup so it is stable through access
    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            prdata <= '0;
        end else if (setup && !pwrite) begin
            prdata <= rd_mux;
        end
    end

endmodule

`default_nettype wire

/* source/instr_fifo.sv */
`default_nettype none

module instr_fifo (
    input  logic        clk,
    input  logic        rst,
    input  logic        push,
    input  logic [15:0] push_data,
    input  logic        pop,
    output logic [15:0] pop_data,
    output logic        full,
    output logic        empty
);
    import ucore_pkg::*;

    logic [15:0]        mem [FIFO_DEPTH];   // word storage
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;              // occupancy 0..depth
    logic               do_push;
    logic               do_pop;

    assign full     = count == (FIFO_AW + 1)'(FIFO_DEPTH);
    assign empty    = count == '0;
    assign do_push  = push && !full;        // overflow ignored
    assign do_pop   = pop && !empty;        // underflow ignored
    assign pop_data = mem[rd_ptr];          // head shows without a pop

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;    // wraps at depth
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // both or neither
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/micro_rom.sv */
`default_nettype none

module micro_rom (
    input  logic [7:0]      uaddr,
    output ucore_pkg::uop_t uop
);
    import ucore_pkg::*;

    logic [3:0] step;                       // position inside a program
    op_t        page;                       // opcode page of the address

    assign step = uaddr[3:0];
    assign page = op_t'(uaddr[7:4]);

    always_comb begin
        uop = U_END;                        // unused slots end the instruction
        if (uaddr[7:4] == UA_FLAGS[7:4]) begin
            // shared flag-write routine
            case (step)
                4'd0:    uop = U_NEXT;      // flags_we raised here
                4'd1:    uop = U_RET;
                default: uop = U_END;
            endcase
        end else begin
            case (page)
                OP_LD, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
                    case (step)
                        4'd0:    uop = U_ALU;
                        4'd1:    uop = U_WRACC;
                        4'd2:    uop = U_CALLF;
                        default: uop = U_END;
                    endcase
                end
                OP_CMP: begin
                    case (step)
                        4'd0:    uop = U_ALU;
                        4'd1:    uop = U_CALLF;     // no acc write
                        default: uop = U_END;
                    endcase
                end
                OP_CLD, OP_CADD: begin
                    case (step)
                        4'd0:    uop = U_SKIPNC;    // test cc first
                        4'd1:    uop = U_ALU;
                        4'd2:    uop = U_WRACC;
                        4'd3:    uop = U_CALLF;
                        default: uop = U_END;
                    endcase
                end
                default: uop = U_END;       // nop page
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/micro_seq.sv */
`default_nettype none

module micro_seq (
    input  logic            clk,
    input  logic            rst,
    input  logic            empty,
    input  logic [15:0]     pop_data,
    input  ucore_pkg::uop_t uop,
    input  logic [7:0]      flags,
    output logic            pop,
    output logic [7:0]      uaddr,
    output ucore_pkg::op_t  op,
    output logic [7:0]      imm,
    output logic            alu_go,
    output logic            acc_we,
    output logic            flags_we,
    output logic            busy_seq
);
    import ucore_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,                             // waiting for a word
        S_DISP,                             // jump to opcode page
        S_RUN                               // one micro-op per cycle
    } state_t;

    state_t     state;
    logic [3:0] cc;                         // latched condition code
    logic [7:0] ret_ua;                     // single return slot
    logic       cc_ok;
    logic       run;
    logic [7:0] nx_ua;                      // next step, same page

    assign run      = state == S_RUN;
    assign nx_ua    = {uaddr[7:4], uaddr[3:0] + 4'd1};
    assign pop      = (state == S_IDLE) && !empty;
    assign busy_seq = state != S_IDLE;
    assign alu_go   = run && (uop == U_ALU);
    assign acc_we   = run && (uop == U_WRACC);
    assign flags_we = run && (uop == U_NEXT);   // NEXT only sits in the flag routine

    // 16 condition codes over the current flags
    always_comb begin
        case (cc)
            4'd0:    cc_ok = 1'b0;
            4'd1:    cc_ok = flags[FS] ^ flags[FV];                 // signed lt
            4'd2:    cc_ok = flags[FZ] | (flags[FS] ^ flags[FV]);   // signed le
            4'd3:    cc_ok = flags[FZ] | flags[FC];                 // unsigned le
            4'd4:    cc_ok = flags[FV];
            4'd5:    cc_ok = flags[FS];
            4'd6:    cc_ok = flags[FZ];
            4'd7:    cc_ok = flags[FC];
            4'd8:    cc_ok = 1'b1;
            4'd9:    cc_ok = ~(flags[FS] ^ flags[FV]);              // signed ge
            4'd10:   cc_ok = ~(flags[FZ] | (flags[FS] ^ flags[FV])); // signed gt
            4'd11:   cc_ok = ~(flags[FZ] | flags[FC]);              // unsigned gt
            4'd12:   cc_ok = ~flags[FV];
            4'd13:   cc_ok = ~flags[FS];
            4'd14:   cc_ok = ~flags[FZ];
            default: cc_ok = ~flags[FC];
        endcase
    end

    // instruction fields taken on pop
    always_ff @(posedge clk) begin
        if (pop) begin
            cc  <= pop_data[11:8];
            imm <= pop_data[7:0];
            if (pop_data[15:12] > OP_CADD) begin
                op <= OP_NOP;               // undefined codes run as nop
            end else begin
                op <= op_t'(pop_data[15:12]);
            end
        end
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state  <= S_IDLE;
            uaddr  <= UA_IDLE;
            ret_ua <= UA_IDLE;
        end else begin
            case (state)
                S_IDLE: if (pop) state <= S_DISP;
                S_DISP: begin
                    uaddr <= {op, 4'd0};    // entry at opcode times 16
                    state <= S_RUN;
                end
                S_RUN: begin
                    case (uop)
                        U_CALLF: begin
                            ret_ua <= nx_ua;
                            uaddr  <= UA_FLAGS;
                        end
                        U_RET: begin
                            uaddr <= ret_ua;
                        end
                        U_SKIPNC: begin
                            if (cc_ok) begin
                                uaddr <= nx_ua;
                            end else begin
                                state <= S_IDLE;    // condition false so nothing is written
                                uaddr <= UA_IDLE;
                            end
                        end
                        U_END: begin
                            state <= S_IDLE;
                            uaddr <= UA_IDLE;
                        end
                        default: uaddr <= nx_ua;    // NEXT ALU WRACC
                    endcase
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/ucore_pkg.sv */
`default_nettype none

package ucore_pkg;

    // host instruction opcodes, bits 15:12 of the command word
    typedef enum logic [3:0] {
        OP_NOP  = 4'h0,             // codes above OP_CADD fold to this
        OP_LD   = 4'h1,             // acc = imm
        OP_ADD  = 4'h2,             // acc = acc + imm
        OP_SUB  = 4'h3,             // acc = acc - imm
        OP_AND  = 4'h4,
        OP_OR   = 4'h5,
        OP_XOR  = 4'h6,
        OP_CMP  = 4'h7,             // flags only
        OP_CLD  = 4'h8,             // LD when cc holds
        OP_CADD = 4'h9              // ADD when cc holds
    } op_t;

    // micro-operations held in the micro rom
    typedef enum logic [2:0] {
        U_NEXT   = 3'd0,            // step on, commits flags inside the routine
        U_ALU    = 3'd1,            // compute into holding regs
        U_WRACC  = 3'd2,            // commit result to acc
        U_CALLF  = 3'd3,            // jump to flag routine
        U_RET    = 3'd4,            // back to caller
        U_SKIPNC = 3'd5,            // abort if cc false
        U_END    = 3'd6             // instruction done
    } uop_t;

    // apb word addresses
    typedef enum logic [3:0] {
        A_CMD    = 4'h0,            // write only, fifo push
        A_ACC    = 4'h4,            // read only
        A_FLAGS  = 4'h8,            // read only
        A_STATUS = 4'hC             // busy full empty in bits 0 1 2
    } reg_addr_t;

    // flag register bit positions
    localparam int FS = 7;          // sign
    localparam int FZ = 6;          // zero
    localparam int FH = 4;          // half carry
    localparam int FV = 2;          // overflow
    localparam int FN = 1;          // subtract
    localparam int FC = 0;          // carry

    // instruction fifo sizing
    localparam int unsigned FIFO_DEPTH = 4;
    localparam int unsigned FIFO_AW    = 2;   // pointer bits

    // fixed micro addresses
    localparam logic [7:0] UA_FLAGS = 8'hF0;  // shared flag-write routine
    localparam logic [7:0] UA_IDLE  = 8'h00;  // parked here when idle

endpackage

`default_nettype wire

/* source/ucore_top.sv */
`default_nettype none

module ucore_top (
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    import ucore_pkg::*;

    logic        push;                      // port to fifo
    logic [15:0] push_data;
    logic        full;
    logic        empty;
    logic        pop;                       // sequencer to fifo
    logic [15:0] pop_data;
    logic [7:0]  uaddr;                     // sequencer to rom
    uop_t        uop;
    op_t         op;                        // sequencer to alu
    logic [7:0]  imm;
    logic        alu_go;
    logic        acc_we;
    logic        flags_we;
    logic        busy_seq;
    logic [7:0]  acc;
    logic [7:0]  flags;

    apb_port u_apb_port (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .full(full), .empty(empty), .busy_seq(busy_seq),
        .acc(acc), .flags(flags),
        .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .push(push), .push_data(push_data)
    );

    instr_fifo u_fifo (
        .clk(clk), .rst(rst),
        .push(push), .push_data(push_data), .pop(pop),
        .pop_data(pop_data), .full(full), .empty(empty)
    );

    micro_seq u_seq (
        .clk(clk), .rst(rst),
        .empty(empty), .pop_data(pop_data), .uop(uop), .flags(flags),
        .pop(pop), .uaddr(uaddr), .op(op), .imm(imm),
        .alu_go(alu_go), .acc_we(acc_we), .flags_we(flags_we),
        .busy_seq(busy_seq)
    );

    micro_rom u_rom (
        .uaddr(uaddr),
        .uop(uop)
    );

    alu_flags u_alu (
        .clk(clk), .rst(rst),
        .op(op), .imm(imm),
        .alu_go(alu_go), .acc_we(acc_we), .flags_we(flags_we),
        .acc(acc), .flags(flags)
    );

endmodule

`default_nettype wire

/* testbench/tb_ucore.sv */
`default_nettype none

module tb_ucore;
    import ucore_pkg::*;

    localparam int N_RANDOM       = 200;            // random program length
    localparam int N_DIRECTED     = 100;            // bound on directed words
    localparam int BURST_LEN      = 10;             // enough to overrun the fifo
    localparam int TIMEOUT_CYCLES = (N_RANDOM + N_DIRECTED) * 40;

    logic        clk = 1'b0;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [7:0]  m_acc;                             // model accumulator
    logic [7:0]  m_flags;                           // model S Z - H - V N C
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    integer      seed   = 32'h0190d588;

    ucore_top u_ucore_top (
        .clk(clk), .rst(rst),
        .psel(psel), .penable(penable), .pwrite(pwrite),
        .paddr(paddr), .pwdata(pwdata),
        .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    // protocol assertions on the apb side and the fifo push
    bind ucore_top ucore_checker u_checker (
        .clk(clk), .rst(rst), .psel(psel), .penable(penable),
        .pslverr(pslverr), .push(push), .full(full)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("[ERROR] %0t %s: got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;                             // setup phase
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;                             // access phase
        @(negedge clk);
        err = pslverr;                              // sampled mid-cycle once settled
        check_bit("pready", pready, 1'b1);          // zero wait states
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data,
                            output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;                              // registered at end of setup
        err  = pslverr;
        check_bit("pready", pready, 1'b1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    // condition table where 9..15 invert 1..7 and 8 inverts 0
    function automatic logic cond_true(input logic [3:0] cc, input logic [7:0] f);
        logic s;
        logic z;
        logic v;
        logic c;
        logic base;
        s = f[7];
        z = f[6];
        v = f[2];
        c = f[0];
        case (cc[2:0])
            3'd0:    base = 1'b0;
            3'd1:    base = s ^ v;
            3'd2:    base = z | (s ^ v);
            3'd3:    base = z | c;
            3'd4:    base = v;
            3'd5:    base = s;
            3'd6:    base = z;
            default: base = c;
        endcase
        return cc[3] ? ~base : base;
    endfunction

    // reference model of one host instruction
    task automatic model_exec(input logic [15:0] w);
        logic [3:0] opc;
        logic [7:0] imm;
        logic [7:0] r;
        logic [7:0] f;
        logic       run_it;
        int         sa;
        int         sb;
        int         t;
        opc    = w[15:12];
        imm    = w[7:0];
        run_it = 1'b1;
        if (opc > 4'd9) opc = OP_NOP;               // undefined codes
        if (opc == OP_CLD || opc == OP_CADD) begin
            run_it = cond_true(w[11:8], m_flags);   // flags before this word
            opc    = (opc == OP_CLD) ? OP_LD : OP_ADD;
        end
        if (opc == OP_NOP) run_it = 1'b0;
        sa = int'($signed(m_acc));
        sb = int'($signed(imm));
        r  = m_acc;
        f  = 8'h00;
        case (opc)
            OP_LD: r = imm;
            OP_ADD: begin
                t    = int'(m_acc) + int'(imm);
                r    = t[7:0];
                f[4] = (int'(m_acc[3:0]) + int'(imm[3:0])) > 15;
                f[2] = (sa + sb > 127) || (sa + sb < -128);
                f[0] = t > 255;
            end
            OP_SUB, OP_CMP: begin
                t    = int'(m_acc) - int'(imm);
                r    = t[7:0];
                f[4] = m_acc[3:0] < imm[3:0];       // nibble borrow
                f[2] = (sa - sb > 127) || (sa - sb < -128);
                f[1] = 1'b1;
                f[0] = m_acc < imm;
            end
            OP_AND: begin
                r    = m_acc & imm;
                f[4] = 1'b1;
            end
            OP_OR:   r = m_acc | imm;
            OP_XOR:  r = m_acc ^ imm;
            default: r = m_acc;
        endcase
        f[7] = r[7];
        f[6] = (r == 8'h00);
        if (run_it) begin
            if (opc != OP_CMP) m_acc = r;           // cmp keeps acc
            m_flags = f;
        end
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        logic        err;
        st = 32'h1;
        while (st[0] || !st[2]) begin               // busy or queued words
            apb_read(A_STATUS, st, err);
            check_bit("pslverr", err, 1'b0);
        end
    endtask

    task automatic check_state();
        logic [31:0] rd;
        logic        err;
        apb_read(A_ACC, rd, err);
        check_bit("pslverr", err, 1'b0);
        check_val("acc", rd, {24'h0, m_acc});
        apb_read(A_FLAGS, rd, err);
        check_bit("pslverr", err, 1'b0);
        check_val("flags", rd, {24'h0, m_flags});
    endtask

    task automatic run_word(input logic [15:0] w);
        logic err;
        apb_write(A_CMD, {16'h0, w}, err);
        check_bit("pslverr", err, 1'b0);            // fifo is idle so the word is taken
        model_exec(w);
        wait_idle();
        check_state();
    endtask

    initial begin
        logic [31:0] rd;
        logic        err;
        logic [15:0] w;
        logic [3:0]  opn;
        op_t         pick;
        integer      rnd;
        int          i;
        int          rejects;
        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 4'h0;
        pwdata  = 32'h0;
        m_acc   = 8'h00;
        m_flags = 8'h00;
        repeat (8) @(posedge clk);
        #1;
        rst = 1'b0;

        // reset values
        check_state();
        apb_read(A_STATUS, rd, err);
        check_bit("pslverr", err, 1'b0);
        check_val("status", rd, 32'h4);             // empty and not busy

        // each alu op once on edge case operands
        run_word({OP_LD,  4'h0, 8'h7F});
        run_word({OP_ADD, 4'h0, 8'h01});            // signed overflow and half carry
        run_word({OP_ADD, 4'h0, 8'h80});            // carry out and zero
        run_word({OP_SUB, 4'h0, 8'h01});            // borrow
        run_word({OP_AND, 4'h0, 8'h0F});
        run_word({OP_OR,  4'h0, 8'hA0});
        run_word({OP_XOR, 4'h0, 8'hAF});
        run_word({OP_CMP, 4'h0, 8'h10});            // flags only
        run_word({OP_NOP, 4'h0, 8'h55});

        // conditional ops over all 16 codes on random flags
        for (i = 0; i < 32; i++) begin
            rnd = $random(seed);
            case (rnd[9:8])
                2'd0:    pick = OP_LD;
                2'd1:    pick = OP_ADD;
                default: pick = OP_SUB;
            endcase
            run_word({pick, 4'h0, rnd[7:0]});
            pick = (i < 16) ? OP_CLD : OP_CADD;
            run_word({pick, i[3:0], rnd[23:16]});
        end

        // back to back writes overrun the fifo
        rejects = 0;
        for (i = 0; i < BURST_LEN; i++) begin
            rnd = $random(seed);
            opn = 4'd1 + 4'({rnd} % 7);             // slow ops from ld through cmp
            w   = {opn, rnd[11:0]};
            apb_write(A_CMD, {16'h0, w}, err);
            if (i < FIFO_DEPTH) check_bit("pslverr", err, 1'b0);
            if (err) begin
                rejects++;
            end else begin
                model_exec(w);
            end
        end
        checks++;
        if (rejects == 0) begin
            errors++;
            $display("burst of %0d writes never found the fifo full", BURST_LEN);
        end
        wait_idle();
        check_state();
        $display("burst: %0d of %0d words rejected on full fifo", rejects, BURST_LEN);

        // illegal accesses leave state alone
        apb_write(A_ACC, 32'h0000_1234, err);
        check_bit("pslverr", err, 1'b1);
        apb_write(A_STATUS, 32'h0000_00FF, err);
        check_bit("pslverr", err, 1'b1);
        apb_read(A_CMD, rd, err);
        check_bit("pslverr", err, 1'b1);
        check_state();
        apb_read(A_STATUS, rd, err);
        check_bit("pslverr", err, 1'b0);
        check_val("status", rd, 32'h4);

        // random program
        for (i = 0; i < N_RANDOM; i++) begin
            rnd = $random(seed);
            run_word(rnd[15:0]);
        end

        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/ucore_checker.sv */
`default_nettype none

module ucore_checker (
    input logic clk,
    input logic rst,
    input logic psel,
    input logic penable,
    input logic pslverr,
    input logic push,
    input logic full
);

    // setup phase always moves on to access
    a_setup_access: assert property (@(posedge clk) disable iff (rst)
        psel && !penable |=> psel && penable)
        else $error("apb setup phase not followed by access phase");

    // no access phase without select
    a_enable_sel: assert property (@(posedge clk) disable iff (rst)
        penable |-> psel)
        else $error("apb penable high without psel");

    a_push_full: assert property (@(posedge clk) disable iff (rst)
        push |-> !full)
        else $error("fifo push while full");

    // error response only in access
    a_err_access: assert property (@(posedge clk) disable iff (rst)
        pslverr |-> psel && penable)
        else $error("pslverr outside the access phase");

endmodule

`default_nettype wire

/* vlog.f */
source/ucore_pkg.sv
source/apb_port.sv
source/instr_fifo.sv
source/micro_rom.sv
source/alu_flags.sv
source/micro_seq.sv
source/ucore_top.sv
testbench/ucore_checker.sv
testbench/tb_ucore.sv
